/* rtl/pet_bus_pkg.sv */
//////////////////////////////////////////////////
// PET memory bus definitions
// Data and address widths, the Wishbone address
// map and the control register layout shared by
// the SPI bridge, the fabric and both slaves
//////////////////////////////////////////////////

package pet_bus_pkg;
    localparam int DATA_W      = 8;
    localparam int WB_ADDR_W   = 20;
    localparam int RAM_ADDR_W  = 17;                    // 128 KiB
    localparam int REGION_W    = WB_ADDR_W - RAM_ADDR_W; // Bits 19..17

    // Address regions
    localparam logic [REGION_W-1:0] REGION_RAM = 3'd0;
    localparam logic [REGION_W-1:0] REGION_REG = 3'd7;

    // Register indices, address bits 1..0
    localparam logic [1:0] REG_ID      = 2'd0;
    localparam logic [1:0] REG_SCRATCH = 2'd1;
    localparam logic [1:0] REG_CTRL    = 2'd2;

    localparam logic [DATA_W-1:0] ID_VALUE      = 8'h50;
    localparam logic [DATA_W-1:0] UNMAPPED_DATA = 8'hFF;

    localparam int CTRL_BE_BIT  = 0;  // Drives cpu_be_o
    localparam int CTRL_LED_BIT = 1;  // 1 = LED on

    localparam int SYNC_STAGES = 2;
endpackage

/* rtl/wb_if.sv */
//////////////////////////////////////////////////
// Wishbone bundle
// Pipelined Wishbone with stall, one master and
// one slave per instance
//////////////////////////////////////////////////

interface wb_if import pet_bus_pkg::*; ();
    logic [WB_ADDR_W-1:0] adr;
    logic [DATA_W-1:0]    dat_w;  // Master to slave
    logic [DATA_W-1:0]    dat_r;  // Slave to master, valid with ack
    logic                 we;
    logic                 cyc;
    logic                 stb;
    logic                 ack;
    logic                 stall;

    modport master (
        output adr, dat_w, we, cyc, stb,
        input  dat_r, ack, stall
    );

    modport slave (
        input  adr, dat_w, we, cyc, stb,
        output dat_r, ack, stall
    );
endinterface

/* rtl/spi_wb_bridge.sv */
//////////////////////////////////////////////////
// SPI to Wishbone bridge
// Oversamples the MCU's SPI pins, collects a
// 3-byte header and turns each frame into one
// Wishbone cycle. Read data goes back in byte 3,
// spi_stall_o is high while the cycle is pending
//////////////////////////////////////////////////

module spi_wb_bridge import pet_bus_pkg::*; (
    input  logic clock_i,
    input  logic arst_n_i,

    input  logic spi_cs_n_i,   // Active low, held for whole frame
    input  logic spi_sck_i,    // Mode 0
    input  logic spi_sd_i,     // MCU -> FPGA
    output logic spi_sd_o,     // FPGA -> MCU
    output logic spi_stall_o,  // High while the bus cycle is pending

    wb_if.master bus
);
    logic [SYNC_STAGES-1:0] cs_sync;
    logic [SYNC_STAGES-1:0] sck_sync;
    logic [SYNC_STAGES-1:0] sd_sync;
    logic                   cs_n;
    logic                   sck;
    logic                   sd;
    logic                   sck_q;
    logic                   sck_rise;
    logic                   sck_fall;

    logic [5:0]             bit_cnt;   // Bits received in this frame
    logic [4*DATA_W-1:0]    rx_sr;
    logic [4*DATA_W-1:0]    rx_next;
    logic [DATA_W-1:0]      tx_sr;
    logic                   start_rd;
    logic                   start_wr;
    logic                   mid_byte;

    // Input synchronizers, CS idles high
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cs_sync  <= '1;
            sck_sync <= '0;
            sd_sync  <= '0;
            sck_q    <= 1'b0;
        end else begin
            cs_sync  <= {cs_sync[SYNC_STAGES-2:0], spi_cs_n_i};
            sck_sync <= {sck_sync[SYNC_STAGES-2:0], spi_sck_i};
            sd_sync  <= {sd_sync[SYNC_STAGES-2:0], spi_sd_i};
            sck_q    <= sck;
        end
    end

    assign cs_n     = cs_sync[SYNC_STAGES-1];
    assign sck      = sck_sync[SYNC_STAGES-1];
    assign sd       = sd_sync[SYNC_STAGES-1];
    assign sck_rise = sck && !sck_q;
    assign sck_fall = !sck && sck_q;

    assign rx_next  = {rx_sr[4*DATA_W-2:0], sd};

    // Write flag is the first bit of the frame
    assign start_rd = sck_rise && !cs_n && !bus.cyc
                   && (bit_cnt == 6'(3*DATA_W - 1)) && !rx_next[3*DATA_W-1];
    assign start_wr = sck_rise && !cs_n && !bus.cyc
                   && (bit_cnt == 6'(4*DATA_W - 1)) && rx_next[4*DATA_W-1];

    // Frame bit counter, cleared by CS high so an aborted frame never starts a cycle
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bit_cnt <= '0;
        end else if (cs_n) begin
            bit_cnt <= '0;
        end else if (sck_rise && bit_cnt != 6'(4*DATA_W)) begin
            bit_cnt <= bit_cnt + 6'd1;  // Saturates after the data byte
        end
    end

    always_ff @(posedge clock_i) begin
        if (sck_rise && !cs_n) begin
            rx_sr <= rx_next;
        end
    end

    // Bus cycle control
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.cyc     <= 1'b0;
            bus.stb     <= 1'b0;
            spi_stall_o <= 1'b0;
        end else if (start_rd || start_wr) begin
            bus.cyc     <= 1'b1;
            bus.stb     <= 1'b1;
            spi_stall_o <= 1'b1;
        end else begin
            if (bus.stb && !bus.stall) begin
                bus.stb <= 1'b0;      // Accepted
            end
            if (bus.cyc && bus.ack) begin
                bus.cyc     <= 1'b0;
                spi_stall_o <= 1'b0;
            end
        end
    end

    // Address, data and direction held until the next frame
    always_ff @(posedge clock_i) begin
        if (start_rd) begin
            bus.adr <= rx_next[WB_ADDR_W-1:0];
            bus.we  <= 1'b0;
        end
        if (start_wr) begin
            bus.adr   <= rx_next[DATA_W +: WB_ADDR_W];
            bus.dat_w <= rx_next[DATA_W-1:0];
            bus.we    <= 1'b1;
        end
    end

    // No shift on the fall that closes a byte, so the read data's MSB
    // waits on the pin until the MCU clocks byte 3
    assign mid_byte = bit_cnt[$clog2(DATA_W)-1:0] != '0;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_sr <= '0;
        end else if (bus.cyc && bus.ack && !bus.we) begin
            tx_sr <= bus.dat_r;
        end else if (sck_fall && !cs_n && mid_byte) begin
            tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
        end
    end

    assign spi_sd_o = tx_sr[DATA_W-1];  // MSB first
endmodule

/* rtl/sram_ctrl.sv */
//////////////////////////////////////////////////
// Asynchronous SRAM controller
// Wishbone slave, three cycles per access with
// every RAM pin registered. Write pulse in cycle
// 2, read strobe in cycles 1 and 2
//////////////////////////////////////////////////

module sram_ctrl import pet_bus_pkg::*; (
    input  logic                  clock_i,
    input  logic                  arst_n_i,

    wb_if.slave                   bus,

    output logic [RAM_ADDR_W-1:0] ram_addr_o,
    input  logic [DATA_W-1:0]     ram_data_i,
    output logic [DATA_W-1:0]     ram_data_o,
    output logic                  ram_data_oe_o,  // High only while writing
    output logic                  ram_oe_o,
    output logic                  ram_we_o
);
    logic [2:0] phase;   // One-hot, cycles 1..3 after acceptance
    logic       accept;

    assign accept    = bus.cyc && bus.stb && !bus.stall;
    assign bus.stall = |phase;
    assign bus.ack   = phase[2];

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase <= '0;
        end else begin
            phase <= {phase[1:0], accept};
        end
    end

    // Pin sequencing
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ram_oe_o      <= 1'b0;
            ram_we_o      <= 1'b0;
            ram_data_oe_o <= 1'b0;
        end else begin
            // Data bus driven for the whole write, so it is stable around the WE pulse
            ram_we_o <= phase[0] && ram_data_oe_o;

            if (accept) begin
                ram_oe_o      <= !bus.we;
                ram_data_oe_o <= bus.we;
            end else begin
                if (phase[1]) begin
                    ram_oe_o <= 1'b0;
                end
                if (phase[2]) begin
                    ram_data_oe_o <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (accept) begin
            ram_addr_o <= bus.adr[RAM_ADDR_W-1:0];
            ram_data_o <= bus.dat_w;
        end
        if (phase[1]) begin
            bus.dat_r <= ram_data_i;  // End of cycle 2, OE still high at the chip
        end
    end
endmodule

/* rtl/ctrl_regs.sv */
//////////////////////////////////////////////////
// Control register bank
// ID, scratch and control registers behind a
// Wishbone slave with single-cycle ack. Control
// bits drive CPU bus enable and the status LED
//////////////////////////////////////////////////

module ctrl_regs import pet_bus_pkg::*; (
    input  logic clock_i,
    input  logic arst_n_i,

    wb_if.slave  bus,

    output logic cpu_be_o,
    output logic status_n_o   // 0 = LED on
);
    logic [DATA_W-1:0] scratch;
    logic [DATA_W-1:0] ctrl;
    logic              accept;
    logic [1:0]        idx;

    assign bus.stall = 1'b0;
    assign accept    = bus.cyc && bus.stb;
    assign idx       = bus.adr[1:0];   // Upper region bits mirror

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
            ctrl    <= '0;
        end else begin
            bus.ack <= accept;
            if (accept && bus.we && idx == REG_CTRL) begin
                ctrl <= bus.dat_w;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (accept && bus.we && idx == REG_SCRATCH) begin
            scratch <= bus.dat_w;
        end
        if (accept) begin
            case (idx)
                REG_ID:      bus.dat_r <= ID_VALUE;
                REG_SCRATCH: bus.dat_r <= scratch;
                REG_CTRL:    bus.dat_r <= ctrl;
                default:     bus.dat_r <= '0;  // Index 3 unused
            endcase
        end
    end

    assign cpu_be_o   = ctrl[CTRL_BE_BIT];
    assign status_n_o = !ctrl[CTRL_LED_BIT];
endmodule

/* rtl/wb_fabric.sv */
//////////////////////////////////////////////////
// Wishbone fabric
// Decodes address bits 19..17 to route the
// master's cycle to the SRAM or the register
// bank, merges their responses and answers
// unmapped addresses itself
//////////////////////////////////////////////////

module wb_fabric import pet_bus_pkg::*; (
    input  logic clock_i,
    input  logic arst_n_i,

    wb_if.slave  master,
    wb_if.master ram,
    wb_if.master regs
);
    logic [REGION_W-1:0] region;
    logic                sel_ram;
    logic                sel_reg;
    logic                unm_ack;

    assign region  = master.adr[WB_ADDR_W-1 -: REGION_W];
    assign sel_ram = region == REGION_RAM;
    assign sel_reg = region == REGION_REG;

    // Request side, only the selected slave sees cyc and stb
    assign ram.adr    = master.adr;
    assign ram.dat_w  = master.dat_w;
    assign ram.we     = master.we;
    assign ram.cyc    = master.cyc && sel_ram;
    assign ram.stb    = master.stb && sel_ram;

    assign regs.adr   = master.adr;
    assign regs.dat_w = master.dat_w;
    assign regs.we    = master.we;
    assign regs.cyc   = master.cyc && sel_reg;
    assign regs.stb   = master.stb && sel_reg;

    assign master.stall = sel_ram ? ram.stall :
                          sel_reg ? regs.stall : 1'b0;

    // Unmapped region, ack one cycle after acceptance
    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            unm_ack <= 1'b0;
        end else begin
            unm_ack <= master.cyc && master.stb && !sel_ram && !sel_reg;
        end
    end

    // Response merge
    assign master.ack   = ram.ack || regs.ack || unm_ack;
    assign master.dat_r = ram.ack  ? ram.dat_r  :
                          regs.ack ? regs.dat_r : UNMAPPED_DATA;
endmodule

/* rtl/pet_mem_top.sv */
//////////////////////////////////////////////////
// PET memory access top level
// SPI bridge, bus fabric, SRAM controller and
// control registers wired to the board pins
//////////////////////////////////////////////////

module pet_mem_top import pet_bus_pkg::*; (
    input  logic                  clock_i,
    input  logic                  arst_n_i,

    // SPI from the MCU
    input  logic                  spi_cs_n_i,
    input  logic                  spi_sck_i,
    input  logic                  spi_sd_i,
    output logic                  spi_sd_o,
    output logic                  spi_stall_o,

    // External SRAM
    output logic [RAM_ADDR_W-1:0] ram_addr_o,
    input  logic [DATA_W-1:0]     ram_data_i,
    output logic [DATA_W-1:0]     ram_data_o,
    output logic                  ram_data_oe_o,
    output logic                  ram_oe_o,
    output logic                  ram_we_o,

    // CPU and status
    output logic                  cpu_be_o,
    output logic                  status_n_o   // 0 = LED on
);
    wb_if bus_m ();    // Bridge to fabric
    wb_if bus_ram ();  // Fabric to SRAM controller
    wb_if bus_reg ();  // Fabric to register bank

    spi_wb_bridge bridge_inst (
        .clock_i     (clock_i),
        .arst_n_i    (arst_n_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_sck_i   (spi_sck_i),
        .spi_sd_i    (spi_sd_i),
        .spi_sd_o    (spi_sd_o),
        .spi_stall_o (spi_stall_o),
        .bus         (bus_m)
    );

    wb_fabric fabric_inst (
        .clock_i  (clock_i),
        .arst_n_i (arst_n_i),
        .master   (bus_m),
        .ram      (bus_ram),
        .regs     (bus_reg)
    );

    sram_ctrl sram_ctrl_inst (
        .clock_i       (clock_i),
        .arst_n_i      (arst_n_i),
        .bus           (bus_ram),
        .ram_addr_o    (ram_addr_o),
        .ram_data_i    (ram_data_i),
        .ram_data_o    (ram_data_o),
        .ram_data_oe_o (ram_data_oe_o),
        .ram_oe_o      (ram_oe_o),
        .ram_we_o      (ram_we_o)
    );

    ctrl_regs ctrl_regs_inst (
        .clock_i    (clock_i),
        .arst_n_i   (arst_n_i),
        .bus        (bus_reg),
        .cpu_be_o   (cpu_be_o),
        .status_n_o (status_n_o)
    );
endmodule

/* sim/sram_model.sv */
//////////////////////////////////////////////////
// Asynchronous SRAM model
// 128 KiB byte array, written on the falling
// edge of WE, read data driven while OE is high
//////////////////////////////////////////////////

module sram_model import pet_bus_pkg::*; (
    input  logic [RAM_ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0]     data_i,   // From the controller
    output logic [DATA_W-1:0]     data_o,   // To the controller
    input  logic                  oe_i,
    input  logic                  we_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [DATA_W-1:0] mem [0:(1 << RAM_ADDR_W) - 1];

    // Chip latches address and data at the end of the WE pulse
    always @(negedge we_i) begin
        mem[addr_i] = data_i;
    end

    assign data_o = oe_i ? mem[addr_i] : '0;  // Bus floats low when not read
endmodule

/* sim/pet_mem_props.sv */
//////////////////////////////////////////////////
// Bus and SRAM pin properties
// Wishbone handshake rules on the bridge bus and
// the SRAM controller, and pin exclusivity
//////////////////////////////////////////////////

module pet_mem_props (
    input logic clock_i,
    input logic arst_n_i,
    input logic m_cyc_i,
    input logic m_stb_i,
    input logic m_ack_i,
    input logic ram_cyc_i,
    input logic ram_stb_i,
    input logic ram_stall_i,
    input logic ram_ack_i,
    input logic ram_we_i,
    input logic ram_oe_i,
    input logic ram_data_oe_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;  // Read by the testbench at the end

    a_stb_cyc: assert property (@(posedge clock_i) disable iff (!arst_n_i)
            m_stb_i |-> m_cyc_i)
        else begin
            fail_cnt++;
            $error("stb high without cyc");
        end

    a_ack_cyc: assert property (@(posedge clock_i) disable iff (!arst_n_i)
            m_ack_i |-> m_cyc_i)
        else begin
            fail_cnt++;
            $error("ack outside a bus cycle");
        end

    // Never drive and read the RAM at once
    a_we_oe: assert property (@(posedge clock_i) disable iff (!arst_n_i)
            !(ram_we_i && ram_oe_i))
        else begin
            fail_cnt++;
            $error("ram_we_o and ram_oe_o both high");
        end

    a_we_dq: assert property (@(posedge clock_i) disable iff (!arst_n_i)
            ram_we_i |-> ram_data_oe_i)
        else begin
            fail_cnt++;
            $error("ram_we_o without data drive");
        end

    a_ram_lat: assert property (@(posedge clock_i) disable iff (!arst_n_i)
            ram_cyc_i && ram_stb_i && !ram_stall_i |-> ##3 ram_ack_i)
        else begin
            fail_cnt++;
            $error("SRAM ack not 3 cycles after acceptance");
        end
endmodule

bind pet_mem_top pet_mem_props props_inst (
    .clock_i       (clock_i),
    .arst_n_i      (arst_n_i),
    .m_cyc_i       (bus_m.cyc),
    .m_stb_i       (bus_m.stb),
    .m_ack_i       (bus_m.ack),
    .ram_cyc_i     (bus_ram.cyc),
    .ram_stb_i     (bus_ram.stb),
    .ram_stall_i   (bus_ram.stall),
    .ram_ack_i     (bus_ram.ack),
    .ram_we_i      (ram_we_o),
    .ram_oe_i      (ram_oe_o),
    .ram_data_oe_i (ram_data_oe_o)
);

/* sim/tb_pet_mem.sv */
//////////////////////////////////////////////////
// PET memory access testbench
// Drives SPI frames into the top level, models the
// SRAM and checks reads against a shadow of the
// address map
//////////////////////////////////////////////////

module tb_pet_mem import pet_bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // 150 frames of about 300 cycles, with margin
    localparam int TIMEOUT_CYCLES = 60000;

    logic                  clock_i;
    logic                  arst_n_i;
    logic                  spi_cs_n;
    logic                  spi_sck;
    logic                  spi_mosi;
    logic                  spi_miso;
    logic                  spi_stall;
    logic [RAM_ADDR_W-1:0] ram_addr;
    logic [DATA_W-1:0]     ram_rd_data;
    logic [DATA_W-1:0]     ram_wr_data;
    logic                  ram_data_oe;
    logic                  ram_oe;
    logic                  ram_we;
    logic                  cpu_be;
    logic                  status_n;

    logic [DATA_W-1:0]     shadow [0:(1 << RAM_ADDR_W) - 1];
    logic [DATA_W-1:0]     scratch_q = '0;
    logic [DATA_W-1:0]     ctrl_q    = '0;
    logic [RAM_ADDR_W-1:0] addr_q [$];   // SRAM addresses written so far
    int                    pass_cnt  = 0;
    int                    err_cnt   = 0;
    int                    cycle_cnt = 0;
    int                    we_pulses = 0;
    logic                  stall_seen = 1'b0;

    pet_mem_top pet_mem_top_inst (
        .clock_i       (clock_i),
        .arst_n_i      (arst_n_i),
        .spi_cs_n_i    (spi_cs_n),
        .spi_sck_i     (spi_sck),
        .spi_sd_i      (spi_mosi),
        .spi_sd_o      (spi_miso),
        .spi_stall_o   (spi_stall),
        .ram_addr_o    (ram_addr),
        .ram_data_i    (ram_rd_data),
        .ram_data_o    (ram_wr_data),
        .ram_data_oe_o (ram_data_oe),
        .ram_oe_o      (ram_oe),
        .ram_we_o      (ram_we),
        .cpu_be_o      (cpu_be),
        .status_n_o    (status_n)
    );

    sram_model sram_inst (
        .addr_i (ram_addr),
        .data_i (ram_wr_data),
        .data_o (ram_rd_data),
        .oe_i   (ram_oe),
        .we_i   (ram_we)
    );

    initial begin
        clock_i = 1'b0;
        forever #20 clock_i = ~clock_i;
    end

    always @(posedge clock_i) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, an SPI frame never completed", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    always @(posedge ram_we) we_pulses++;
    always @(negedge clock_i) if (spi_stall) stall_seen = 1'b1;

    // Address map rules for what a read must return
    function automatic logic [DATA_W-1:0] expected_read(input logic [WB_ADDR_W-1:0] addr);
        logic [REGION_W-1:0] region;
        region = addr[WB_ADDR_W-1:RAM_ADDR_W];
        if (region == REGION_RAM) return shadow[addr[RAM_ADDR_W-1:0]];
        if (region != REGION_REG) return UNMAPPED_DATA;
        case (addr[1:0])
            REG_ID:      return ID_VALUE;
            REG_SCRATCH: return scratch_q;
            REG_CTRL:    return ctrl_q;
            default:     return '0;
        endcase
    endfunction

    function automatic void update_shadow(input logic [WB_ADDR_W-1:0] addr,
                                          input logic [DATA_W-1:0] data);
        logic [REGION_W-1:0] region;
        region = addr[WB_ADDR_W-1:RAM_ADDR_W];
        if (region == REGION_RAM) begin
            shadow[addr[RAM_ADDR_W-1:0]] = data;
        end else if (region == REGION_REG && addr[1:0] == REG_SCRATCH) begin
            scratch_q = data;
        end else if (region == REGION_REG && addr[1:0] == REG_CTRL) begin
            ctrl_q = data;
        end
    endfunction

    function automatic logic [WB_ADDR_W-1:0] reg_addr(input logic [1:0] idx);
        return {REGION_REG, {(WB_ADDR_W - REGION_W - 2){1'b0}}, idx};
    endfunction

    task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            err_cnt++;
        end else begin
            $display("ok      %s: %h", name, act);
            pass_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            err_cnt++;
        end else begin
            $display("ok      %s: %b", name, act);
            pass_cnt++;
        end
    endtask

    // One SPI bit, mode 0, SCK half period of 4 clocks
    task automatic spi_bit(input logic tx, output logic rx);
        spi_mosi = tx;
        repeat (4) @(negedge clock_i);
        spi_sck = 1'b1;
        rx = spi_miso;
        repeat (4) @(negedge clock_i);
        spi_sck = 1'b0;
    endtask

    task automatic spi_byte(input logic [DATA_W-1:0] tx, output logic [DATA_W-1:0] rx);
        logic r;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            spi_bit(tx[i], r);
            rx[i] = r;
        end
    endtask

    task automatic start_frame();
        spi_cs_n = 1'b0;
        repeat (4) @(negedge clock_i);
    endtask

    task automatic end_frame();
        repeat (4) @(negedge clock_i);
        spi_cs_n = 1'b1;
        repeat (8) @(negedge clock_i);
    endtask

    task automatic wait_stall_low();
        while (spi_stall) @(negedge clock_i);
    endtask

    task automatic spi_write(input logic [WB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] rx;
        start_frame();
        spi_byte({1'b1, 3'b000, addr[WB_ADDR_W-1:16]}, rx);
        spi_byte(addr[15:8], rx);
        spi_byte(addr[7:0], rx);
        spi_byte(data, rx);
        wait_stall_low();
        end_frame();
        update_shadow(addr, data);
    endtask

    task automatic spi_read(input logic [WB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] rx;
        start_frame();
        spi_byte({1'b0, 3'b000, addr[WB_ADDR_W-1:16]}, rx);
        spi_byte(addr[15:8], rx);
        spi_byte(addr[7:0], rx);
        wait_stall_low();          // Read data is loaded when stall drops
        spi_byte('0, data);
        end_frame();
    endtask

    task automatic read_check(input string name, input logic [WB_ADDR_W-1:0] addr);
        logic [DATA_W-1:0] got;
        spi_read(addr, got);
        check_byte(name, expected_read(addr), got);
    endtask

    task automatic write_ctrl(input logic [DATA_W-1:0] data);
        spi_write(reg_addr(REG_CTRL), data);
        check_bit($sformatf("ctrl %h cpu_be_o", data), data[CTRL_BE_BIT], cpu_be);
        check_bit($sformatf("ctrl %h status_n_o", data), !data[CTRL_LED_BIT], status_n);
        read_check($sformatf("ctrl %h readback", data), reg_addr(REG_CTRL));
    endtask

    initial begin
        logic [31:0]           rnd;
        logic [RAM_ADDR_W-1:0] a;
        logic [WB_ADDR_W-1:0]  unm;
        int                    k;
        int                    pulses_before;
        int                    prop_fails;

        void'($urandom(5785));
        arst_n_i = 1'b0;
        spi_cs_n = 1'b1;
        spi_sck  = 1'b0;
        spi_mosi = 1'b0;
        repeat (16) @(negedge clock_i);
        arst_n_i = 1'b1;
        repeat (4) @(negedge clock_i);

        check_bit("reset spi_stall_o", 1'b0, spi_stall);
        check_bit("reset ram_we_o", 1'b0, ram_we);
        check_bit("reset ram_oe_o", 1'b0, ram_oe);
        check_bit("reset ram_data_oe_o", 1'b0, ram_data_oe);
        check_bit("reset cpu_be_o", 1'b0, cpu_be);
        check_bit("reset status_n_o", 1'b1, status_n);

        read_check("id read", reg_addr(REG_ID));
        spi_write(reg_addr(REG_SCRATCH), 8'hA5);
        read_check("scratch readback", reg_addr(REG_SCRATCH));
        spi_write(reg_addr(2'd3), 8'h3C);
        read_check("index 3 reads zero", reg_addr(2'd3));

        write_ctrl(8'h01);
        write_ctrl(8'h02);
        write_ctrl(8'h03);

        // Every sixth write lands on an address already used
        for (int i = 0; i < 60; i++) begin
            rnd = $urandom();
            a = rnd[RAM_ADDR_W-1:0];
            if (i % 6 == 5) begin
                k = $urandom_range(addr_q.size() - 1);
                a = addr_q[k];
            end
            addr_q.push_back(a);
            rnd = $urandom();
            spi_write({REGION_RAM, a}, rnd[31:24]);
        end
        foreach (addr_q[i]) begin
            read_check($sformatf("sram read %0d", i), {REGION_RAM, addr_q[i]});
        end

        unm = {3'd3, addr_q[0]};   // Same low bits as a live SRAM byte
        read_check("unmapped read", unm);
        pulses_before = we_pulses;
        spi_write(unm, ~shadow[addr_q[0]]);
        check_bit("unmapped write no ram_we_o", 1'b0, we_pulses != pulses_before);
        read_check("sram after unmapped write", {REGION_RAM, addr_q[0]});
        read_check("scratch after unmapped write", reg_addr(REG_SCRATCH));
        read_check("ctrl after unmapped write", reg_addr(REG_CTRL));

        // Two write frames aborted after two header bytes each
        // A bit count kept across CS would reach 32 and start a write
        stall_seen = 1'b0;
        repeat (2) begin
            start_frame();
            spi_byte({1'b1, 3'b000, REGION_RAM, addr_q[1][RAM_ADDR_W-1:16]}, rnd[7:0]);
            spi_byte(addr_q[1][15:8], rnd[7:0]);
            end_frame();
        end
        check_bit("aborted frame no stall", 1'b0, stall_seen);
        read_check("sram after abort", {REGION_RAM, addr_q[1]});

        prop_fails = int'(pet_mem_top_inst.props_inst.fail_cnt);
        if (prop_fails != 0) begin
            $display("Bus property checks failed %0d times during the run", prop_fails);
            err_cnt += prop_fails;
        end
        $display("Checks done: %0d passed, %0d failed", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule

/* project.f */
rtl/pet_bus_pkg.sv
rtl/wb_if.sv
rtl/spi_wb_bridge.sv
rtl/sram_ctrl.sv
rtl/ctrl_regs.sv
rtl/wb_fabric.sv
rtl/pet_mem_top.sv
sim/sram_model.sv
sim/pet_mem_props.sv
sim/tb_pet_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PET memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_pet_mem -f project.f -o tb_pet_mem

# Property failures are counted by the testbench, so let the run continue past them
out=$(./obj_dir/tb_pet_mem +verilator+error+limit+1000 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -Fqx "PASS: all tests"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
